// ==== tests/sgb_tests.txt ====
# P/C: 16 packet bytes (C inserts a corrupt pulse after byte 0)   V: vblank
# X: shade colour tint exp_colour exp_pal_en exp_freeze   J: mlt pulses p54 pad0-3 exp_joy_do
X 0 1234 0 1234 0 0
X 3 0abc 0 0abc 0 0
P 01 ff 7f e0 03 1f 00 00 7c 11 22 33 44 55 66 00
X 0 1234 0 7fff 1 0
X 1 1234 0 03e0 1 0
X 2 1234 0 001f 1 0
X 3 1234 0 7c00 1 0
X 2 1234 1 1234 0 0
P 09 21 04 aa 2a bb 3b cc 4c 01 02 03 04 05 06 00
X 0 1234 0 0421 1 0
X 1 1234 0 03e0 1 0
P b9 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00
X 1 1234 0 03e0 1 0
V
X 1 1234 0 03e0 1 1
P b9 02 00 00 00 00 00 00 00 00 00 00 00 00 00 00
V
X 1 1234 0 0000 1 0
X 2 1234 1 0000 1 0
P b9 03 00 00 00 00 00 00 00 00 00 00 00 00 00 00
V
X 3 5555 0 0421 1 0
P b9 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
V
X 3 1234 0 7c00 1 0
X 2 1234 1 1234 0 0
P 89 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00
J 1 0 3 21 42 84 18 f
J 1 1 3 21 42 84 18 e
J 1 1 3 21 42 84 18 f
J 1 0 2 21 42 84 18 e
J 1 0 1 21 42 84 18 d
J 1 0 3 21 42 84 18 e
J 1 0 2 21 42 84 18 d
J 1 0 1 21 42 84 18 b
J 1 0 3 21 42 84 18 f
P 89 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
J 0 0 3 21 42 84 18 f
J 0 1 3 21 42 84 18 f
J 0 0 2 21 42 84 18 c
J 0 0 1 21 42 84 18 9
C 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
X 0 1234 0 0421 1 0
X 1 1234 0 03e0 1 0
X 2 1234 0 001f 1 0
X 3 1234 0 7c00 1 0

// ==== tb.f ====
source/sgb_pkg.sv
source/sgb_packet_rx.sv
source/sgb_cmd_decode.sv
source/sgb_joypad_mux.sv
source/sgb_colorize.sv
source/sgb_top.sv
tests/tb_sgb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_sgb -f tb.f -o tb_sgb \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sgb > sim.log 2>&1 \
	|| { cat sim.log; echo "Simulation exited abnormally"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"

// ==== tests/tb_sgb.sv ====
`timescale 1ns/100ps

module tb_sgb;

	localparam int    PERIOD = 100;
	localparam int    DRIVE_DELAY = 10;
	localparam int    CLOCKS_PER_LINE = 1200;
	localparam string TESTS_FILE = "tests/sgb_tests.txt";

	logic            clk_sys;
	logic            reset;
	logic            sgb_en;
	logic            tint;
	logic [1:0]      joy_p54;
	logic [7:0]      joystick_0;
	logic [7:0]      joystick_1;
	logic [7:0]      joystick_2;
	logic [7:0]      joystick_3;
	sgb_pkg::color_t lcd_data;
	sgb_pkg::shade_t lcd_data_gb;
	logic            lcd_clkena;
	logic [1:0]      lcd_mode;
	logic            lcd_on;
	logic            lcd_vsync;
	logic [3:0]      joy_do;
	sgb_pkg::color_t sgb_lcd_data;
	logic            sgb_lcd_clkena;
	logic [1:0]      sgb_lcd_mode;
	logic            sgb_lcd_on;
	logic            sgb_lcd_vsync;
	logic            sgb_lcd_freeze;
	logic            sgb_pal_en;

	logic [7:0] pkt [16];
	int         line_count = 0;
	int         test_count = 0;
	int         error_count = 0;

	sgb_top u_dut (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.sgb_en         (sgb_en),
		.tint           (tint),
		.joy_p54        (joy_p54),
		.joystick_0     (joystick_0),
		.joystick_1     (joystick_1),
		.joystick_2     (joystick_2),
		.joystick_3     (joystick_3),
		.lcd_data       (lcd_data),
		.lcd_data_gb    (lcd_data_gb),
		.lcd_clkena     (lcd_clkena),
		.lcd_mode       (lcd_mode),
		.lcd_on         (lcd_on),
		.lcd_vsync      (lcd_vsync),
		.joy_do         (joy_do),
		.sgb_lcd_data   (sgb_lcd_data),
		.sgb_lcd_clkena (sgb_lcd_clkena),
		.sgb_lcd_mode   (sgb_lcd_mode),
		.sgb_lcd_on     (sgb_lcd_on),
		.sgb_lcd_vsync  (sgb_lcd_vsync),
		.sgb_lcd_freeze (sgb_lcd_freeze),
		.sgb_pal_en     (sgb_pal_en)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Budget grows with the number of lines in the tests file
	initial begin
		wait (line_count > 0);
		repeat (line_count * CLOCKS_PER_LINE) @(posedge clk_sys);
		$display("Timeout, tests did not finish within %0d clocks", line_count * CLOCKS_PER_LINE);
		$display("Finished with errors");
		$finish;
	end

	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	task automatic hold_lines(input logic [1:0] p54, input int clocks);
		joy_p54 = p54;
		repeat (clocks) next_cycle();
	endtask

	task automatic compare_color(input string name, input sgb_pkg::color_t got,
		input sgb_pkg::color_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_nibble(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_mode(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic report_test(input int line_no, input string what, input int errors_before);
		test_count++;
		$display("Test %0d (line %0d) %s: %s", test_count, line_no, what,
			(error_count == errors_before) ? "ok" : "FAILED");
	endtask

	task automatic report_bad_line(input int line_no);
		$display("Line %0d of %s cannot be parsed", line_no, TESTS_FILE);
		error_count++;
	endtask

	// Reset pulse, then 128 bits LSB first; P15 low is a one
	task automatic send_packet(input bit corrupt);
		hold_lines(2'b00, 4);
		hold_lines(2'b11, 4);
		for (int i = 0; i < 16; i++) begin
			for (int b = 0; b < 8; b++) begin
				hold_lines(pkt[i][b] ? 2'b01 : 2'b10, 4);
				hold_lines(2'b11, 4);
			end
			// P15 drops while P14 is still low
			if (corrupt && i == 0) begin
				hold_lines(2'b10, 4);
				hold_lines(2'b01, 4);
				hold_lines(2'b11, 4);
			end
		end
	endtask

	// Control outputs trail their inputs by two clocks
	task automatic check_lcd_ctrl(input logic exp_clkena, input logic [1:0] exp_mode,
		input logic exp_on, input logic exp_vsync);
		compare_flag("sgb_lcd_clkena", sgb_lcd_clkena, exp_clkena);
		compare_mode("sgb_lcd_mode", sgb_lcd_mode, exp_mode);
		compare_flag("sgb_lcd_on", sgb_lcd_on, exp_on);
		compare_flag("sgb_lcd_vsync", sgb_lcd_vsync, exp_vsync);
	endtask

	task automatic apply_vblank(input int line_no);
		int errors_before;
		errors_before = error_count;
		lcd_mode = 2'd1;
		lcd_vsync = 1'b1;
		lcd_clkena = 1'b0;
		lcd_on = 1'b0;
		next_cycle();
		check_lcd_ctrl(1'b1, 2'd3, 1'b1, 1'b0);
		next_cycle();
		check_lcd_ctrl(1'b0, 2'd1, 1'b0, 1'b1);
		lcd_mode = 2'd3;
		lcd_vsync = 1'b0;
		lcd_clkena = 1'b1;
		lcd_on = 1'b1;
		next_cycle();
		check_lcd_ctrl(1'b0, 2'd1, 1'b0, 1'b1);
		next_cycle();
		check_lcd_ctrl(1'b1, 2'd3, 1'b1, 1'b0);
		report_test(line_no, "vblank", errors_before);
	endtask

	task automatic check_pixel(input int line_no, input sgb_pkg::shade_t shade,
		input sgb_pkg::color_t color, input logic tint_in, input sgb_pkg::color_t exp_color,
		input logic exp_pal_en, input logic exp_freeze);
		int errors_before;
		errors_before = error_count;
		lcd_data_gb = shade;
		lcd_data = color;
		tint = tint_in;
		// Two pipeline stages
		next_cycle();
		next_cycle();
		compare_color("sgb_lcd_data", sgb_lcd_data, exp_color);
		compare_flag("sgb_pal_en", sgb_pal_en, exp_pal_en);
		compare_flag("sgb_lcd_freeze", sgb_lcd_freeze, exp_freeze);
		report_test(line_no, $sformatf("pixel shade %0d tint %0d", shade, tint_in), errors_before);
	endtask

	task automatic check_joypad(input int line_no, input logic [1:0] mlt, input int pulses,
		input logic [1:0] p54, input logic [31:0] pads, input logic [3:0] exp);
		int errors_before;
		errors_before = error_count;
		{joystick_3, joystick_2, joystick_1, joystick_0} = pads;
		repeat (pulses) begin
			hold_lines(2'b01, 1);
			hold_lines(2'b11, 1);
		end
		hold_lines(p54, 1);
		compare_nibble("joy_do", joy_do, exp);
		// Back to idle, a P15 rise here steps the identity
		hold_lines(2'b11, 1);
		report_test(line_no, $sformatf("joypad mlt_ctrl %0d p54 %b", mlt, p54), errors_before);
	endtask

	task automatic count_lines();
		int fd;
		int n;
		string line;
		fd = $fopen(TESTS_FILE, "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n != 0)
					line_count++;
			end
			$fclose(fd);
		end
	endtask

	task automatic run_tests();
		int          fd;
		int          n;
		int          line_no;
		string       line;
		string       rest;
		byte         kind;
		logic [31:0] fld [8];
		line_no = 0;
		fd = $fopen(TESTS_FILE, "r");
		if (fd == 0) begin
			$display("Could not open %s", TESTS_FILE);
			error_count++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			line_no++;
			kind = line.getc(0);
			if (n == 0 || kind == "#" || kind == "\n")
				continue;
			rest = line.substr(1, line.len() - 1);
			case (kind)
				"P", "C": begin
					n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						pkt[0], pkt[1], pkt[2], pkt[3], pkt[4], pkt[5], pkt[6], pkt[7],
						pkt[8], pkt[9], pkt[10], pkt[11], pkt[12], pkt[13], pkt[14], pkt[15]);
					if (n != 16)
						report_bad_line(line_no);
					else
						send_packet(kind == "C");
				end
				"X": begin
					n = $sscanf(rest, "%h %h %h %h %h %h",
						fld[0], fld[1], fld[2], fld[3], fld[4], fld[5]);
					if (n != 6)
						report_bad_line(line_no);
					else
						check_pixel(line_no, fld[0][1:0], fld[1][14:0], fld[2][0],
							fld[3][14:0], fld[4][0], fld[5][0]);
				end
				"J": begin
					n = $sscanf(rest, "%h %h %h %h %h %h %h %h",
						fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7]);
					if (n != 8)
						report_bad_line(line_no);
					else
						check_joypad(line_no, fld[0][1:0], int'(fld[1]), fld[2][1:0],
							{fld[6][7:0], fld[5][7:0], fld[4][7:0], fld[3][7:0]}, fld[7][3:0]);
				end
				"V": apply_vblank(line_no);
				default: report_bad_line(line_no);
			endcase
		end
		$fclose(fd);
	endtask

	initial begin
		reset = 1'b1;
		sgb_en = 1'b1;
		tint = 1'b0;
		joy_p54 = 2'b11;
		joystick_0 = '0;
		joystick_1 = '0;
		joystick_2 = '0;
		joystick_3 = '0;
		lcd_data = '0;
		lcd_data_gb = '0;
		lcd_clkena = 1'b1;
		lcd_mode = 2'd3;
		lcd_on = 1'b1;
		lcd_vsync = 1'b0;
		count_lines();
		repeat (5) @(posedge clk_sys);
		#DRIVE_DELAY;
		reset = 1'b0;
		next_cycle();
		run_tests();
		$display("Tests run: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== source/sgb_top.sv ====
`timescale 1ns/100ps

module sgb_top (
	input  logic            clk_sys,
	input  logic            reset,
	input  logic            sgb_en,
	input  logic            tint,
	input  logic [1:0]      joy_p54,
	input  logic [7:0]      joystick_0,
	input  logic [7:0]      joystick_1,
	input  logic [7:0]      joystick_2,
	input  logic [7:0]      joystick_3,
	input  sgb_pkg::color_t lcd_data,
	input  sgb_pkg::shade_t lcd_data_gb,
	input  logic            lcd_clkena,
	input  logic [1:0]      lcd_mode,
	input  logic            lcd_on,
	input  logic            lcd_vsync,
	output logic [3:0]      joy_do,
	output sgb_pkg::color_t sgb_lcd_data,
	output logic            sgb_lcd_clkena,
	output logic [1:0]      sgb_lcd_mode,
	output logic            sgb_lcd_on,
	output logic            sgb_lcd_vsync,
	output logic            sgb_lcd_freeze,
	output logic            sgb_pal_en
);

	logic            byte_valid;
	logic [7:0]      byte_data;
	logic [3:0]      byte_index;
	logic            pal_wr;
	sgb_pkg::shade_t pal_wr_slot;
	sgb_pkg::color_t pal_wr_color;
	logic [1:0]      mlt_ctrl;
	sgb_pkg::mask_e  mask_req;

	sgb_packet_rx u_packet_rx (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sgb_en     (sgb_en),
		.joy_p54    (joy_p54),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_index (byte_index)
	);

	sgb_cmd_decode u_cmd_decode (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.byte_valid   (byte_valid),
		.byte_data    (byte_data),
		.byte_index   (byte_index),
		.pal_wr       (pal_wr),
		.pal_wr_slot  (pal_wr_slot),
		.pal_wr_color (pal_wr_color),
		.mlt_ctrl     (mlt_ctrl),
		.mask_req     (mask_req)
	);

	sgb_joypad_mux u_joypad_mux (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sgb_en     (sgb_en),
		.joy_p54    (joy_p54),
		.mlt_ctrl   (mlt_ctrl),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.joystick_2 (joystick_2),
		.joystick_3 (joystick_3),
		.joy_do     (joy_do)
	);

	sgb_colorize u_colorize (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.sgb_en         (sgb_en),
		.tint           (tint),
		.pal_wr         (pal_wr),
		.pal_wr_slot    (pal_wr_slot),
		.pal_wr_color   (pal_wr_color),
		.mask_req       (mask_req),
		.lcd_data       (lcd_data),
		.lcd_data_gb    (lcd_data_gb),
		.lcd_clkena     (lcd_clkena),
		.lcd_mode       (lcd_mode),
		.lcd_on         (lcd_on),
		.lcd_vsync      (lcd_vsync),
		.sgb_lcd_data   (sgb_lcd_data),
		.sgb_lcd_clkena (sgb_lcd_clkena),
		.sgb_lcd_mode   (sgb_lcd_mode),
		.sgb_lcd_on     (sgb_lcd_on),
		.sgb_lcd_vsync  (sgb_lcd_vsync),
		.sgb_lcd_freeze (sgb_lcd_freeze),
		.sgb_pal_en     (sgb_pal_en)
	);

endmodule

// ==== source/sgb_colorize.sv ====
`timescale 1ns/100ps

module sgb_colorize (
	input  logic            clk_sys,
	input  logic            reset,
	input  logic            sgb_en,
	input  logic            tint,
	input  logic            pal_wr,
	input  sgb_pkg::shade_t pal_wr_slot,
	input  sgb_pkg::color_t pal_wr_color,
	input  sgb_pkg::mask_e  mask_req,
	input  sgb_pkg::color_t lcd_data,
	input  sgb_pkg::shade_t lcd_data_gb,
	input  logic            lcd_clkena,
	input  logic [1:0]      lcd_mode,
	input  logic            lcd_on,
	input  logic            lcd_vsync,
	output sgb_pkg::color_t sgb_lcd_data,
	output logic            sgb_lcd_clkena,
	output logic [1:0]      sgb_lcd_mode,
	output logic            sgb_lcd_on,
	output logic            sgb_lcd_vsync,
	output logic            sgb_lcd_freeze,
	output logic            sgb_pal_en
);

	sgb_pkg::color_t palette [4];
	sgb_pkg::mask_e  mask;
	sgb_pkg::color_t lcd_data_r;
	sgb_pkg::shade_t lcd_data_gb_r;

	logic       pal_active;
	logic       lcd_off;
	logic       pass_through;
	logic       lcd_clkena_r;
	logic       lcd_on_r;
	logic       lcd_vsync_r;
	logic [1:0] lcd_mode_r;

	// Screen off or vblank
	assign lcd_off = !lcd_on || (lcd_mode == 2'd1);

	assign pass_through = !sgb_en ||
		((!pal_active || tint) && mask == sgb_pkg::MASK_OFF);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < 4; i++)
				palette[i] <= '0;
			pal_active <= 1'b0;
			mask <= sgb_pkg::MASK_OFF;
		end else begin
			if (pal_wr) begin
				palette[pal_wr_slot] <= pal_wr_color;
				pal_active <= 1'b1;
			end
			// Mask changes only between frames
			if (lcd_off)
				mask <= mask_req;
		end
	end

	// Stage 1
	always_ff @(posedge clk_sys) begin
		lcd_data_r <= lcd_data;
		lcd_data_gb_r <= lcd_data_gb;
		lcd_clkena_r <= lcd_clkena;
		lcd_mode_r <= lcd_mode;
		lcd_on_r <= lcd_on;
		lcd_vsync_r <= lcd_vsync;
	end

	// Stage 2
	always_ff @(posedge clk_sys) begin
		if (pass_through)
			sgb_lcd_data <= lcd_data_r;
		else if (mask == sgb_pkg::MASK_BLACK)
			sgb_lcd_data <= '0;
		else if (lcd_data_gb_r == 2'd0 || mask == sgb_pkg::MASK_COLOR0)
			sgb_lcd_data <= palette[0];
		else
			sgb_lcd_data <= palette[lcd_data_gb_r];
		sgb_lcd_clkena <= lcd_clkena_r;
		sgb_lcd_mode <= lcd_mode_r;
		sgb_lcd_on <= lcd_on_r;
		sgb_lcd_vsync <= lcd_vsync_r;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sgb_lcd_freeze <= 1'b0;
			sgb_pal_en <= 1'b0;
		end else begin
			sgb_lcd_freeze <= sgb_en && mask == sgb_pkg::MASK_FREEZE;
			sgb_pal_en <= sgb_en && ((pal_active && !tint) || mask != sgb_pkg::MASK_OFF);
		end
	end

endmodule

// ==== source/sgb_joypad_mux.sv ====
`timescale 1ns/100ps

module sgb_joypad_mux (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       sgb_en,
	input  logic [1:0] joy_p54,
	input  logic [1:0] mlt_ctrl,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  logic [7:0] joystick_2,
	input  logic [7:0] joystick_3,
	output logic [3:0] joy_do
);

	logic       p14;
	logic       p15;
	logic       old_p15;
	logic [1:0] joypad_id;
	logic [7:0] pad;
	logic [3:0] dir_n;
	logic [3:0] btn_n;

	assign p14 = joy_p54[0];
	assign p15 = joy_p54[1];

	// Identity steps on P15 rising, wraps through the mlt_ctrl mask
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_p15 <= 1'b1;
			joypad_id <= '0;
		end else begin
			old_p15 <= p15;
			if (sgb_en && !old_p15 && p15)
				joypad_id <= (joypad_id + 2'd1) & mlt_ctrl;
			else
				joypad_id <= joypad_id & mlt_ctrl;
		end
	end

	always_comb begin
		if (!sgb_en || !mlt_ctrl[0]) begin
			pad = joystick_0 | joystick_1;
		end else begin
			case (joypad_id)
				2'd0: pad = joystick_0;
				2'd1: pad = joystick_1;
				2'd2: pad = joystick_2;
				default: pad = joystick_3;
			endcase
		end
	end

	// Active low, a high select line hides its group
	assign dir_n = ~pad[3:0] | {4{p14}};
	assign btn_n = ~pad[7:4] | {4{p15}};

	assign joy_do = (sgb_en && p14 && p15) ? ~{2'b00, joypad_id} : (dir_n & btn_n);

endmodule

// ==== source/sgb_cmd_decode.sv ====
`timescale 1ns/100ps

module sgb_cmd_decode (
	input  logic            clk_sys,
	input  logic            reset,
	input  logic            byte_valid,
	input  logic [7:0]      byte_data,
	input  logic [3:0]      byte_index,
	output logic            pal_wr,
	output sgb_pkg::shade_t pal_wr_slot,
	output sgb_pkg::color_t pal_wr_color,
	output logic [1:0]      mlt_ctrl,
	output sgb_pkg::mask_e  mask_req
);

	sgb_pkg::cmd_e cmd;

	logic [2:0] length;
	logic [2:0] packet_cnt;
	logic [7:0] color_lo;
	logic       is_pal_cmd;
	logic       first_is_pal0;
	logic       last_byte;

	assign is_pal_cmd = (cmd == sgb_pkg::PAL01) || (cmd == sgb_pkg::PAL23) ||
		(cmd == sgb_pkg::PAL03) || (cmd == sgb_pkg::PAL12);

	// Only these two name palette 0 as their first palette
	assign first_is_pal0 = (cmd == sgb_pkg::PAL01) || (cmd == sgb_pkg::PAL03);

	assign last_byte = (byte_index == 4'(sgb_pkg::PACKET_BYTES - 1));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd <= sgb_pkg::PAL01;
			length <= '0;
			packet_cnt <= '0;
			mlt_ctrl <= '0;
			mask_req <= sgb_pkg::MASK_OFF;
		end else if (byte_valid) begin
			if (packet_cnt == 3'd0 && byte_index == 4'd0) begin
				cmd <= sgb_pkg::cmd_e'(byte_data[7:3]);
				length <= byte_data[2:0];
			end

			if (byte_index == 4'd1) begin
				case (cmd)
					sgb_pkg::MLT_REQ: mlt_ctrl <= byte_data[1:0];
					sgb_pkg::MASK_EN: mask_req <= sgb_pkg::mask_e'(byte_data[1:0]);
					default: ;
				endcase
			end

			// A length of 0 behaves as 1
			if (last_byte) begin
				if ({1'b0, packet_cnt} + 4'd1 >= {1'b0, length})
					packet_cnt <= '0;
				else
					packet_cnt <= packet_cnt + 3'd1;
			end
		end
	end

	// Even byte completes a colour; slot 0 is shared by all palettes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pal_wr <= 1'b0;
		end else begin
			pal_wr <= 1'b0;
			if (byte_valid && is_pal_cmd && byte_index != 4'd0 && !byte_index[0])
				pal_wr <= (byte_index == 4'd2) || (first_is_pal0 && byte_index <= 4'd8);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_valid) begin
			if (byte_index[0]) begin
				color_lo <= byte_data;
			end else begin
				pal_wr_color <= {byte_data[6:0], color_lo};
				// Bytes 2, 4, 6, 8 map to slots 0 to 3
				pal_wr_slot <= sgb_pkg::shade_t'(byte_index[3:1] - 3'd1);
			end
		end
	end

endmodule

// ==== source/sgb_packet_rx.sv ====
`timescale 1ns/100ps

module sgb_packet_rx (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       sgb_en,
	input  logic [1:0] joy_p54,
	output logic       byte_valid,
	output logic [7:0] byte_data,
	output logic [3:0] byte_index
);

	sgb_pkg::rx_state_e state;

	logic       p14;
	logic       p15;
	logic       old_p14;
	logic       old_p15;
	logic [7:0] shift;
	logic [2:0] bit_cnt;
	logic [3:0] byte_cnt;
	logic       reset_pulse;
	logic       bit_edge;
	logic       corrupt;

	assign p14 = joy_p54[0];
	assign p15 = joy_p54[1];

	assign reset_pulse = !p14 && !p15;

	// Both lines were high, now exactly one is low
	assign bit_edge = old_p14 && old_p15 && (p14 ^ p15);

	// P15 moved while one line stayed low on both clocks
	assign corrupt = (old_p15 ^ p15) && (old_p15 ^ old_p14) && (p15 ^ p14);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= sgb_pkg::RX_IDLE;
			old_p14 <= 1'b1;
			old_p15 <= 1'b1;
			bit_cnt <= '0;
			byte_cnt <= '0;
			byte_valid <= 1'b0;
		end else begin
			old_p14 <= p14;
			old_p15 <= p15;
			byte_valid <= 1'b0;

			if (sgb_en) begin
				if (reset_pulse) begin
					state <= sgb_pkg::RX_RECEIVE;
					bit_cnt <= '0;
					byte_cnt <= '0;
				end else if (corrupt) begin
					state <= sgb_pkg::RX_IDLE;
				end else if (bit_edge && state == sgb_pkg::RX_RECEIVE) begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						byte_valid <= 1'b1;
						byte_cnt <= byte_cnt + 4'd1;
						// Next packet needs its own reset pulse
						if (byte_cnt == 4'(sgb_pkg::PACKET_BYTES - 1))
							state <= sgb_pkg::RX_IDLE;
					end
				end
			end
		end
	end

	// Bits come LSB first, P15 low is a one
	always_ff @(posedge clk_sys) begin
		if (sgb_en && bit_edge && state == sgb_pkg::RX_RECEIVE) begin
			shift <= {!p15, shift[7:1]};
			if (bit_cnt == 3'd7) begin
				byte_data <= {!p15, shift[7:1]};
				byte_index <= byte_cnt;
			end
		end
	end

endmodule

// ==== source/sgb_pkg.sv ====
package sgb_pkg;

	// One packet is always sixteen bytes
	localparam int PACKET_BYTES = 16;

	// Command codes from the top five bits of byte 0
	typedef enum logic [4:0] {
		PAL01   = 5'h00,
		PAL23   = 5'h01,
		PAL03   = 5'h02,
		PAL12   = 5'h03,
		MLT_REQ = 5'h11,
		MASK_EN = 5'h17
	} cmd_e;

	typedef enum logic {
		RX_IDLE,
		RX_RECEIVE
	} rx_state_e;

	typedef enum logic [1:0] {
		MASK_OFF,
		MASK_FREEZE,
		MASK_BLACK,
		MASK_COLOR0
	} mask_e;

	// BGR555
	typedef logic [14:0] color_t;

	// Game Boy shade, also the colour slot within a palette
	typedef logic [1:0] shade_t;

endpackage
